/* verilog/mips_isa_pkg.sv */
package mips_isa_pkg;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	localparam logic [5:0] OP_SPECIAL  = 6'h00;
	localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
	localparam logic [5:0] OP_ADDI     = 6'h08;
	localparam logic [5:0] OP_ADDIU    = 6'h09;
	localparam logic [5:0] OP_SLTI     = 6'h0a;
	localparam logic [5:0] OP_SLTIU    = 6'h0b;
	localparam logic [5:0] OP_ANDI     = 6'h0c;
	localparam logic [5:0] OP_ORI      = 6'h0d;
	localparam logic [5:0] OP_XORI     = 6'h0e;
	localparam logic [5:0] OP_LUI      = 6'h0f;
	localparam logic [5:0] OP_LB       = 6'h20;
	localparam logic [5:0] OP_LH       = 6'h21;
	localparam logic [5:0] OP_LW       = 6'h23;
	localparam logic [5:0] OP_LBU      = 6'h24;
	localparam logic [5:0] OP_LHU      = 6'h25;
	localparam logic [5:0] OP_SB       = 6'h28;
	localparam logic [5:0] OP_SH       = 6'h29;
	localparam logic [5:0] OP_SW       = 6'h2b;

	// funct field of OP_SPECIAL
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_SRL   = 6'h02;
	localparam logic [5:0] FN_SRA   = 6'h03;
	localparam logic [5:0] FN_SLLV  = 6'h04;
	localparam logic [5:0] FN_SRLV  = 6'h06;
	localparam logic [5:0] FN_SRAV  = 6'h07;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MTHI  = 6'h11;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MTLO  = 6'h13;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1a;
	localparam logic [5:0] FN_DIVU  = 6'h1b;
	localparam logic [5:0] FN_ADD   = 6'h20;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUB   = 6'h22;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_NOR   = 6'h27;
	localparam logic [5:0] FN_SLT   = 6'h2a;
	localparam logic [5:0] FN_SLTU  = 6'h2b;

	localparam logic [5:0] FN2_MUL = 6'h02; // funct field of OP_SPECIAL2
	localparam logic [5:0] FN2_CLZ = 6'h20;
	localparam logic [5:0] FN2_CLO = 6'h21;

endpackage

/* verilog/decode_ctrl_pkg.sv */
package decode_ctrl_pkg;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_CLZ  = 4'd2,
		ALU_CLO  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_NOR  = 4'd8,
		ALU_XOR  = 4'd9,
		ALU_LUI  = 4'd10
	} alu_op_e;

	typedef enum logic [1:0] {
		SH_NONE = 2'd0,
		SH_LEFT = 2'd1,
		SH_SRL  = 2'd2,
		SH_SRA  = 2'd3
	} shift_op_e;

	typedef enum logic [2:0] {
		RES_NONE  = 3'd0,
		RES_ALU   = 3'd1,
		RES_SHIFT = 3'd2,
		RES_MDU   = 3'd4
	} result_sel_e;

	typedef enum logic [1:0] {
		RD_RT   = 2'd0,
		RD_RD   = 2'd1,
		RD_NONE = 2'd2
	} regdst_e;

	typedef enum logic [3:0] {
		MDU_NONE  = 4'd0,
		MDU_DIV   = 4'd1,
		MDU_DIVU  = 4'd2,
		MDU_MUL   = 4'd3,
		MDU_MULT  = 4'd4,
		MDU_MULTU = 4'd5,
		MDU_MFHI  = 4'd6,
		MDU_MFLO  = 4'd7,
		MDU_MTHI  = 4'd8,
		MDU_MTLO  = 4'd9
	} mdu_op_e;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic        bus_err; // read came back with a nonzero rresp
	} fetch_item_t;

	typedef struct packed {
		alu_op_e     alu_op;
		shift_op_e   shift_op;
		logic        shift_sel;   // shift amount taken from rs instead of shamt
		logic        alu_b_sel;   // b operand is the extended immediate
		logic        imm_zext;
		result_sel_e result_sel;
		logic        regwr;
		regdst_e     regdst;
		logic        dmen;
		logic        memrd;
		logic        memwr;
		logic [3:0]  bytesel;
		logic        load_signed;
		mdu_op_e     mdu_op;
		logic        of_ctrl;     // trap on signed overflow
		logic        illegal;
	} id_ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		id_ctrl_t    ctrl;
	} decoded_item_t;

endpackage

/* verilog/instr_fetch.sv */
`timescale 1ns/10ps

module instr_fetch import mips_isa_pkg::*, decode_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	output logic        push,
	output fetch_item_t push_item,
	input  logic        full
);

	logic [31:0] pc;      // address of the next request
	logic [31:0] req_pc;  // address of the read in flight
	logic        waiting; // address accepted and data not back yet
	logic        ar_hs;

	assign ar_hs  = arvalid && arready;
	assign araddr = pc;
	assign rready = 1'b1;

	// the response is only taken while a read is in flight
	assign push = rvalid && rready && waiting;

	assign push_item.pc      = req_pc;
	assign push_item.instr   = rdata;
	assign push_item.bus_err = (rresp != 2'b00);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= RESET_PC;
			arvalid <= 1'b0;
			waiting <= 1'b0;
		end else begin
			if (ar_hs) begin
				arvalid <= 1'b0;
				waiting <= 1'b1;
				pc      <= pc + 32'd4;
			end else if (!arvalid && !waiting && !full) begin
				arvalid <= 1'b1; // only fetch fills the queue so room is checked before asking
			end
			if (push) begin
				waiting <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			req_pc <= pc;
		end
	end

endmodule

/* verilog/stage_fifo.sv */
`timescale 1ns/10ps

module stage_fifo import decode_ctrl_pkg::*; #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_item,
	output logic     full,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_item
);

	payload_t            mem [QUEUE_DEPTH];
	logic [QUEUE_AW-1:0] wr_ptr;
	logic [QUEUE_AW-1:0] rd_ptr;
	logic [QUEUE_AW:0]   count;
	logic                empty;
	logic                wr_en;
	logic                pop;

	assign wr_en     = push && !full;
	assign pop       = out_valid && out_ready;
	assign out_valid = !empty;
	assign out_item  = mem[rd_ptr]; // head entry only changes on a pop

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_item;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			case ({wr_en, pop})
				2'b10: begin
					count <= count + 1'b1;
					full  <= (count == (QUEUE_AW + 1)'(QUEUE_DEPTH - 1));
					empty <= 1'b0;
				end
				2'b01: begin
					count <= count - 1'b1;
					full  <= 1'b0;
					empty <= (count == (QUEUE_AW + 1)'(1));
				end
				default: ;
			endcase
		end
	end

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode import mips_isa_pkg::*, decode_ctrl_pkg::*; (
	input  logic          in_valid,
	output logic          in_ready,
	input  fetch_item_t   in_item,
	output logic          dec_valid,
	input  logic          dec_ready,
	output decoded_item_t dec_item
);

	logic [5:0] op;
	logic [5:0] fn;
	logic       r_alu;     // register form alu ops including clz and clo
	logic       i_alu;
	logic       shift;
	logic       shift_sel;
	logic       load;
	logic       store;
	logic       mdu;
	logic       mdu_wr;    // mul, mfhi and mflo hand a value back to the register file
	logic       acc_word;
	logic       acc_half;
	logic       acc_byte;
	logic       supported;
	logic       illegal;
	alu_op_e    alu_op;
	shift_op_e  shift_op;
	mdu_op_e    mdu_op;
	id_ctrl_t   ctrl;

	assign op = in_item.instr[31:26];
	assign fn = in_item.instr[5:0];

	assign r_alu = (op == OP_SPECIAL && fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
			FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU}) ||
		(op == OP_SPECIAL2 && fn inside {FN2_CLZ, FN2_CLO});
	assign i_alu = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	assign shift = op == OP_SPECIAL && fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
	assign shift_sel = op == OP_SPECIAL && fn inside {FN_SLLV, FN_SRLV, FN_SRAV};
	assign load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign store = op inside {OP_SB, OP_SH, OP_SW};
	assign mdu    = (mdu_op != MDU_NONE);
	assign mdu_wr = mdu_op inside {MDU_MUL, MDU_MFHI, MDU_MFLO};

	assign acc_word = op inside {OP_LW, OP_SW};
	assign acc_half = op inside {OP_LH, OP_LHU, OP_SH};
	assign acc_byte = op inside {OP_LB, OP_LBU, OP_SB};

	assign supported = r_alu || i_alu || shift || load || store || mdu;
	assign illegal   = !supported || in_item.bus_err; // branches, jumps and cop0 land here too

	always_comb begin
		alu_op = ALU_ADD; // loads and stores add base and offset
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_SUB, FN_SUBU: alu_op = ALU_SUB;
					FN_AND:          alu_op = ALU_AND;
					FN_OR:           alu_op = ALU_OR;
					FN_XOR:          alu_op = ALU_XOR;
					FN_NOR:          alu_op = ALU_NOR;
					FN_SLT:          alu_op = ALU_SLT;
					FN_SLTU:         alu_op = ALU_SLTU;
					default:         alu_op = ALU_ADD;
				endcase
			end
			OP_SPECIAL2: begin
				if (fn == FN2_CLZ)
					alu_op = ALU_CLZ;
				else if (fn == FN2_CLO)
					alu_op = ALU_CLO;
			end
			OP_SLTI:  alu_op = ALU_SLT;
			OP_SLTIU: alu_op = ALU_SLTU;
			OP_ANDI:  alu_op = ALU_AND;
			OP_ORI:   alu_op = ALU_OR;
			OP_XORI:  alu_op = ALU_XOR;
			OP_LUI:   alu_op = ALU_LUI;
			default:  alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		if (!shift)
			shift_op = SH_NONE;
		else if (fn == FN_SLL || fn == FN_SLLV)
			shift_op = SH_LEFT;
		else if (fn == FN_SRL || fn == FN_SRLV)
			shift_op = SH_SRL;
		else
			shift_op = SH_SRA;
	end

	always_comb begin
		mdu_op = MDU_NONE;
		if (op == OP_SPECIAL) begin
			case (fn)
				FN_DIV:   mdu_op = MDU_DIV;
				FN_DIVU:  mdu_op = MDU_DIVU;
				FN_MULT:  mdu_op = MDU_MULT;
				FN_MULTU: mdu_op = MDU_MULTU;
				FN_MFHI:  mdu_op = MDU_MFHI;
				FN_MFLO:  mdu_op = MDU_MFLO;
				FN_MTHI:  mdu_op = MDU_MTHI;
				FN_MTLO:  mdu_op = MDU_MTLO;
				default:  mdu_op = MDU_NONE;
			endcase
		end else if (op == OP_SPECIAL2 && fn == FN2_MUL) begin
			mdu_op = MDU_MUL;
		end
	end

	always_comb begin
		ctrl         = '0;
		ctrl.regdst  = RD_NONE;
		ctrl.illegal = 1'b1;
		if (!illegal) begin
			ctrl.illegal     = 1'b0;
			ctrl.alu_op      = alu_op;
			ctrl.shift_op    = shift_op;
			ctrl.shift_sel   = shift_sel;
			ctrl.alu_b_sel   = i_alu || load || store;
			ctrl.imm_zext    = op inside {OP_ANDI, OP_ORI, OP_XORI};
			ctrl.regwr       = r_alu || i_alu || shift || load || mdu_wr;
			ctrl.dmen        = load || store;
			ctrl.memrd       = load;
			ctrl.memwr       = store;
			ctrl.bytesel     = acc_word ? 4'b1111 : acc_half ? 4'b0011 : acc_byte ? 4'b0001 : 4'b0000;
			ctrl.load_signed = op inside {OP_LB, OP_LH};
			ctrl.mdu_op      = mdu_op;
			ctrl.of_ctrl     = (op == OP_SPECIAL && fn inside {FN_ADD, FN_SUB}) || op == OP_ADDI;
			if (shift)
				ctrl.result_sel = RES_SHIFT;
			else if (mdu)
				ctrl.result_sel = RES_MDU;
			else
				ctrl.result_sel = RES_ALU;
			if (i_alu || load)
				ctrl.regdst = RD_RT;
			else if (ctrl.regwr)
				ctrl.regdst = RD_RD;
		end
	end

	assign dec_valid      = in_valid;
	assign in_ready       = dec_ready;
	assign dec_item.pc    = in_item.pc;
	assign dec_item.instr = in_item.instr;
	assign dec_item.ctrl  = ctrl;

endmodule

/* verilog/mips_decode_top.sv */
`timescale 1ns/10ps

module mips_decode_top import decode_ctrl_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	output logic          arvalid,
	input  logic          arready,
	output logic [31:0]   araddr,
	input  logic          rvalid,
	output logic          rready,
	input  logic [31:0]   rdata,
	input  logic [1:0]    rresp,
	output logic          out_valid,
	input  logic          out_ready,
	output decoded_item_t out_item
);

	logic          fetch_push;
	fetch_item_t   fetch_item;
	logic          fetch_full;
	logic          fq_valid;
	logic          fq_ready;
	fetch_item_t   fq_item;
	logic          dec_valid;
	logic          dec_ready;
	decoded_item_t dec_item;
	logic          dec_full;

	assign dec_ready = !dec_full; // output queue accepts whenever it has a free slot

	instr_fetch u_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.rresp     (rresp),
		.push      (fetch_push),
		.push_item (fetch_item),
		.full      (fetch_full)
	);

	stage_fifo #(.payload_t(fetch_item_t)) u_fetch_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (fetch_push),
		.push_item (fetch_item),
		.full      (fetch_full),
		.out_valid (fq_valid),
		.out_ready (fq_ready),
		.out_item  (fq_item)
	);

	instr_decode u_decode (
		.in_valid  (fq_valid),
		.in_ready  (fq_ready),
		.in_item   (fq_item),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec_item  (dec_item)
	);

	stage_fifo #(.payload_t(decoded_item_t)) u_dec_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (dec_valid && dec_ready),
		.push_item (dec_item),
		.full      (dec_full),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_item  (out_item)
	);

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* tests/mips_decode_chk.sv */
`timescale 1ns/10ps

module mips_decode_chk import mips_isa_pkg::*, decode_ctrl_pkg::*; (
	input logic          clk,
	input logic          rst_n,
	input logic          arvalid,
	input logic          arready,
	input logic [31:0]   araddr,
	input logic          rvalid,
	input logic          rready,
	input logic          out_valid,
	input logic          out_ready,
	input decoded_item_t out_item
);

	logic [31:0] next_addr; // address the next read request must carry
	logic [31:0] next_pc;   // pc the next output item must carry
	logic        pending;
	bit          reset_fail;
	bit          ar_hold_fail;
	bit          ar_overlap_fail;
	bit          ar_addr_fail;
	bit          r_accept_fail;
	bit          order_fail;
	bit          stall_fail;
	logic        failed;

	assign failed = reset_fail || ar_hold_fail || ar_overlap_fail || ar_addr_fail ||
		r_accept_fail || order_fail || stall_fail;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			next_addr <= RESET_PC;
			next_pc   <= RESET_PC;
			pending   <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				next_addr <= next_addr + 32'd4;
				pending   <= 1'b1;
			end else if (rvalid && rready) begin
				pending <= 1'b0;
			end
			if (out_valid && out_ready)
				next_pc <= next_pc + 32'd4;
		end
	end

	reset_idle: assert property (@(posedge clk) !rst_n |=> !arvalid && !out_valid)
		else begin
			reset_fail = 1'b1;
			$error("arvalid or out_valid high right after reset");
		end

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			ar_hold_fail = 1'b1;
			$error("read request dropped or its address moved before arready");
		end

	ar_single: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && arready |-> !pending)
		else begin
			ar_overlap_fail = 1'b1;
			$error("second read accepted while the first response is still due");
		end

	ar_sequence: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid |-> araddr == next_addr)
		else begin
			ar_addr_fail = 1'b1;
			$error("read address 0x%08h, next sequential address 0x%08h", araddr, next_addr);
		end

	r_accept: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> rready)
		else begin
			r_accept_fail = 1'b1;
			$error("rready low while a read response is on the bus");
		end

	out_order: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_item.pc == next_pc)
		else begin
			order_fail = 1'b1;
			$error("output pc 0x%08h out of order, next pc 0x%08h", out_item.pc, next_pc);
		end

	out_stall: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_item))
		else begin
			stall_fail = 1'b1;
			$error("output item changed or vanished while stalled");
		end

endmodule

bind mips_decode_top mips_decode_chk u_chk (.*);

/* tests/mips_decode_tb.sv */
`timescale 1ns/10ps

module mips_decode_tb import mips_isa_pkg::*, decode_ctrl_pkg::*; ();

	localparam int          NUM_TESTS       = 24;
	localparam int          WATCHDOG_CYCLES = NUM_TESTS * 40;
	localparam int          PAT_LEN         = 256;
	localparam int          DELAY_LEN       = 64;
	localparam logic [31:0] ERR_ADDR        = 32'd92; // entry 23 comes back with SLVERR
	localparam logic [31:0] SEED            = 32'h38bd50ad;

	logic          clk;
	logic          rst_n;
	logic          arvalid;
	logic          arready;
	logic [31:0]   araddr;
	logic          rvalid;
	logic          rready;
	logic [31:0]   rdata;
	logic [1:0]    rresp;
	logic          out_valid;
	logic          out_ready;
	decoded_item_t out_item;

	logic [31:0] prog_word [NUM_TESTS];
	id_ctrl_t    prog_ctrl [NUM_TESTS];
	string       prog_name [NUM_TESTS];
	int          prog_len;
	int unsigned ar_delay [DELAY_LEN];
	bit          ready_pat [PAT_LEN];

	tb_clock_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mips_decode_top dut (.*);

	function automatic logic [31:0] rtype_word(logic [5:0] op, logic [5:0] fn, logic [4:0] sh);
		return {op, 5'd1, 5'd2, 5'd3, sh, fn};
	endfunction

	function automatic logic [31:0] itype_word(logic [5:0] op, logic [15:0] imm);
		return {op, 5'd4, 5'd5, imm};
	endfunction

	// a register write happens exactly when there is a destination
	function automatic id_ctrl_t base_ctrl(alu_op_e alu_op, result_sel_e res, regdst_e dst);
		id_ctrl_t c;
		c            = '0;
		c.alu_op     = alu_op;
		c.result_sel = res;
		c.regdst     = dst;
		c.regwr      = (dst != RD_NONE);
		return c;
	endfunction

	function automatic id_ctrl_t r_alu_ctrl(alu_op_e alu_op, logic of);
		id_ctrl_t c;
		c         = base_ctrl(alu_op, RES_ALU, RD_RD);
		c.of_ctrl = of;
		return c;
	endfunction

	function automatic id_ctrl_t imm_alu_ctrl(alu_op_e alu_op, logic zext, logic of);
		id_ctrl_t c;
		c           = base_ctrl(alu_op, RES_ALU, RD_RT);
		c.alu_b_sel = 1'b1;
		c.imm_zext  = zext;
		c.of_ctrl   = of;
		return c;
	endfunction

	function automatic id_ctrl_t shift_ctrl(shift_op_e sh, logic from_rs);
		id_ctrl_t c;
		c           = base_ctrl(ALU_ADD, RES_SHIFT, RD_RD);
		c.shift_op  = sh;
		c.shift_sel = from_rs;
		return c;
	endfunction

	function automatic id_ctrl_t mem_ctrl(logic is_load, logic [3:0] lanes, logic sgn);
		id_ctrl_t c;
		c             = base_ctrl(ALU_ADD, RES_ALU, is_load ? RD_RT : RD_NONE);
		c.alu_b_sel   = 1'b1;
		c.dmen        = 1'b1;
		c.memrd       = is_load;
		c.memwr       = !is_load;
		c.bytesel     = lanes;
		c.load_signed = sgn;
		return c;
	endfunction

	function automatic id_ctrl_t muldiv_ctrl(mdu_op_e op, regdst_e dst);
		id_ctrl_t c;
		c        = base_ctrl(ALU_ADD, RES_MDU, dst);
		c.mdu_op = op;
		return c;
	endfunction

	function automatic id_ctrl_t illegal_ctrl();
		id_ctrl_t c;
		c         = '0;
		c.regdst  = RD_NONE;
		c.illegal = 1'b1;
		return c;
	endfunction

	task automatic put_entry(string name, logic [31:0] word, id_ctrl_t ctrl);
		prog_name[prog_len] = name;
		prog_word[prog_len] = word;
		prog_ctrl[prog_len] = ctrl;
		prog_len++;
	endtask

	task automatic fill_program();
		prog_len = 0;
		put_entry("add", rtype_word(OP_SPECIAL, FN_ADD, 5'd0), r_alu_ctrl(ALU_ADD, 1'b1));
		put_entry("subu", rtype_word(OP_SPECIAL, FN_SUBU, 5'd0), r_alu_ctrl(ALU_SUB, 1'b0));
		put_entry("and", rtype_word(OP_SPECIAL, FN_AND, 5'd0), r_alu_ctrl(ALU_AND, 1'b0));
		put_entry("nor", rtype_word(OP_SPECIAL, FN_NOR, 5'd0), r_alu_ctrl(ALU_NOR, 1'b0));
		put_entry("sltu", rtype_word(OP_SPECIAL, FN_SLTU, 5'd0), r_alu_ctrl(ALU_SLTU, 1'b0));
		put_entry("clz", rtype_word(OP_SPECIAL2, FN2_CLZ, 5'd0), r_alu_ctrl(ALU_CLZ, 1'b0));
		put_entry("addi", itype_word(OP_ADDI, 16'hfff0), imm_alu_ctrl(ALU_ADD, 1'b0, 1'b1));
		put_entry("ori", itype_word(OP_ORI, 16'h00ff), imm_alu_ctrl(ALU_OR, 1'b1, 1'b0));
		put_entry("slti", itype_word(OP_SLTI, 16'h8000), imm_alu_ctrl(ALU_SLT, 1'b0, 1'b0));
		put_entry("lui", itype_word(OP_LUI, 16'h1234), imm_alu_ctrl(ALU_LUI, 1'b0, 1'b0));
		put_entry("sll", rtype_word(OP_SPECIAL, FN_SLL, 5'd5), shift_ctrl(SH_LEFT, 1'b0));
		put_entry("srav", rtype_word(OP_SPECIAL, FN_SRAV, 5'd0), shift_ctrl(SH_SRA, 1'b1));
		put_entry("lb", itype_word(OP_LB, 16'h0004), mem_ctrl(1'b1, 4'b0001, 1'b1));
		put_entry("lhu", itype_word(OP_LHU, 16'h0006), mem_ctrl(1'b1, 4'b0011, 1'b0));
		put_entry("lw", itype_word(OP_LW, 16'h0008), mem_ctrl(1'b1, 4'b1111, 1'b0));
		put_entry("sb", itype_word(OP_SB, 16'h0001), mem_ctrl(1'b0, 4'b0001, 1'b0));
		put_entry("sh", itype_word(OP_SH, 16'h0002), mem_ctrl(1'b0, 4'b0011, 1'b0));
		put_entry("sw", itype_word(OP_SW, 16'h000c), mem_ctrl(1'b0, 4'b1111, 1'b0));
		put_entry("mult", rtype_word(OP_SPECIAL, FN_MULT, 5'd0), muldiv_ctrl(MDU_MULT, RD_NONE));
		put_entry("divu", rtype_word(OP_SPECIAL, FN_DIVU, 5'd0), muldiv_ctrl(MDU_DIVU, RD_NONE));
		put_entry("mflo", rtype_word(OP_SPECIAL, FN_MFLO, 5'd0), muldiv_ctrl(MDU_MFLO, RD_RD));
		put_entry("mul", rtype_word(OP_SPECIAL2, FN2_MUL, 5'd0), muldiv_ctrl(MDU_MUL, RD_RD));
		put_entry("beq", itype_word(6'h04, 16'h0010), illegal_ctrl()); // beq is not decoded
		put_entry("xori_slverr", itype_word(OP_XORI, 16'h5a5a), illegal_ctrl());
	endtask

	task automatic make_random_stimulus();
		bit level;
		int left;
		level = 1'b0;
		left  = 0;
		for (int i = 0; i < DELAY_LEN; i++)
			ar_delay[i] = $urandom_range(3, 0);
		// alternate ready stretches with shorter stall stretches
		for (int i = 0; i < PAT_LEN; i++) begin
			if (left == 0) begin
				level = !level;
				left  = level ? $urandom_range(6, 1) : $urandom_range(4, 1);
			end
			ready_pat[i] = level;
			left--;
		end
	endtask

	task automatic fail_mismatch(string test, string field, logic [63:0] exp, logic [63:0] act);
		$display("** Error %s: %s expected %h, actual %h", test, field, exp, act);
		$display("Test failures found");
		$fatal(1, "decoded item does not match the program table");
	endtask

	task automatic abort_run(string why);
		$display("Test failures found");
		$fatal(1, "%s", why);
	endtask

	task automatic check_item(decoded_item_t item);
		int idx;
		assert (item.pc < 32'(NUM_TESTS * 4) && item.pc[1:0] == 2'b00)
			else abort_run("output item carries a pc outside the program");
		idx = int'(item.pc[31:2]);
		assert (item.instr == prog_word[idx])
			else fail_mismatch(prog_name[idx], "instr", 64'(prog_word[idx]), 64'(item.instr));
		if (prog_ctrl[idx].illegal) begin
			assert (item.ctrl.illegal && !item.ctrl.regwr && !item.ctrl.dmen && !item.ctrl.memwr)
				else abort_run("illegal word came out with a write or memory enable set");
		end
		assert (item.ctrl == prog_ctrl[idx])
			else fail_mismatch(prog_name[idx], "ctrl", 64'(prog_ctrl[idx]), 64'(item.ctrl));
	endtask

	// AXI4-Lite read slave with one read in flight and a random address wait
	initial begin
		logic [31:0] addr;
		int          reads;
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		rresp   = 2'b00;
		reads   = 0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			#1;
			if (arvalid) begin
				repeat (ar_delay[reads % DELAY_LEN]) begin
					@(posedge clk);
					#1;
				end
				reads++;
				addr    = araddr;
				arready = 1'b1;
				@(posedge clk);
				#1;
				arready = 1'b0;
				rvalid  = 1'b1;
				rdata   = (addr < 32'(NUM_TESTS * 4)) ? prog_word[addr[31:2]] : 32'h0; // nop past the end
				rresp   = (addr == ERR_ADDR) ? 2'b10 : 2'b00;
				@(posedge clk);
				#1;
				rvalid = 1'b0;
				rresp  = 2'b00;
			end
		end
	end

	initial begin
		int received;
		int cycle;
		out_ready = 1'b0;
		received  = 0;
		cycle     = 0;
		void'($urandom(SEED));
		make_random_stimulus();
		fill_program();
		wait (rst_n === 1'b1);
		while (received < NUM_TESTS) begin
			@(posedge clk);
			#1;
			out_ready = ready_pat[cycle % PAT_LEN];
			cycle++;
			if (out_valid && out_ready) begin
				check_item(out_item);
				received++;
			end
		end
		@(posedge clk); // the last transfer completes on this edge
		#1;
		if (dut.u_chk.failed) begin
			$display("Test failures found");
			$fatal(1, "protocol assertion failed");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (dut.u_chk.failed) begin
			$display("Test failures found");
			$fatal(1, "protocol assertion failed in the bound checker");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("timeout, not all decoded items arrived in time");
	end

endmodule

/* mips_decode_top.f */
verilog/mips_isa_pkg.sv
verilog/decode_ctrl_pkg.sv
verilog/instr_fetch.sv
verilog/stage_fifo.sv
verilog/instr_decode.sv
verilog/mips_decode_top.sv
tests/tb_clock_gen.sv
tests/mips_decode_chk.sv
tests/mips_decode_tb.sv
